/* hw/soc_fabric_pkg.sv */
// address map, widths and channel types of the fabric
// AXI4-Lite only: single beats, no ids and no prot
package soc_fabric_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	localparam int STRB_W = DATA_W / 8;

	// ----------------------------------------
	// address map
	// ----------------------------------------
	localparam logic [ADDR_W-1:0] DRAM_BASE  = 32'h8000_0000;
	localparam logic [ADDR_W-1:0] DRAM_LEN   = 32'h1000_0000;
	localparam logic [ADDR_W-1:0] PERIP_BASE = 32'h4000_0000;
	localparam logic [ADDR_W-1:0] PERIP_LEN  = 32'h1000_0000;
	localparam logic [ADDR_W-1:0] CLINT_BASE = 32'h0200_0000;
	localparam logic [ADDR_W-1:0] CLINT_LEN  = 32'h000C_0000;

	// clint registers, relative to CLINT_BASE
	localparam logic [ADDR_W-1:0] MSIP_OFS     = 32'h0000_0000;
	localparam logic [ADDR_W-1:0] MTIMECMP_OFS = 32'h0000_4000;
	localparam logic [ADDR_W-1:0] MTIME_OFS    = 32'h0000_BFF8;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_DECERR = 2'b11;

	typedef enum logic [1:0] {
		TGT_DRAM,
		TGT_PERIP,
		TGT_CLINT,
		TGT_NONE
	} tgt_e;

	// one access inside the fabric
	typedef struct packed {
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] wstrb;
	} fab_req_t;

	typedef struct packed {
		logic              we;
		logic [DATA_W-1:0] rdata;
		logic [1:0]        resp;
	} fab_rsp_t;

	// master-driven side of an AXI4-Lite port
	typedef struct packed {
		logic [ADDR_W-1:0] aw_addr;
		logic              aw_valid;
		logic [DATA_W-1:0] w_data;
		logic [STRB_W-1:0] w_strb;
		logic              w_valid;
		logic              b_ready;
		logic [ADDR_W-1:0] ar_addr;
		logic              ar_valid;
		logic              r_ready;
	} axil_req_t;

	// slave-driven side
	typedef struct packed {
		logic              aw_ready;
		logic              w_ready;
		logic [1:0]        b_resp;
		logic              b_valid;
		logic              ar_ready;
		logic [DATA_W-1:0] r_data;
		logic [1:0]        r_resp;
		logic              r_valid;
	} axil_rsp_t;

endpackage

/* hw/axil_front.sv */
// AXI4-Lite slave side of the fabric
// AW and W are taken only together; responses return in request order
module axil_front (
	input  logic                      sys_clk,
	input  logic                      ndmreset_n,
	input  soc_fabric_pkg::axil_req_t s_req_i,
	output soc_fabric_pkg::axil_rsp_t s_rsp_o,
	output logic                      req_valid_o,
	input  logic                      req_ready_i,
	output soc_fabric_pkg::fab_req_t  req_o,
	input  logic                      rsp_valid_i,
	output logic                      rsp_ready_o,
	input  soc_fabric_pkg::fab_rsp_t  rsp_i
);
	import soc_fabric_pkg::*;

	logic wr_pend;
	logic rd_pend;
	logic pick_wr;
	logic sel_wr;
	logic last_wr_q;
	logic lock_q;
	logic lock_wr_q;

	// ----------------------------------------
	// request side
	// ----------------------------------------
	assign wr_pend = s_req_i.aw_valid & s_req_i.w_valid;
	assign rd_pend = s_req_i.ar_valid;

	// alternate when both wait
	assign pick_wr = wr_pend & (~rd_pend | ~last_wr_q);
	// hold the choice while the slice stalls
	assign sel_wr = lock_q ? lock_wr_q : pick_wr;

	assign req_valid_o = wr_pend | rd_pend;
	assign req_o.we    = sel_wr;
	assign req_o.addr  = sel_wr ? s_req_i.aw_addr : s_req_i.ar_addr;
	assign req_o.wdata = sel_wr ? s_req_i.w_data : '0;
	assign req_o.wstrb = sel_wr ? s_req_i.w_strb : '0;

	assign s_rsp_o.aw_ready = req_valid_o & req_ready_i & sel_wr;
	assign s_rsp_o.w_ready  = req_valid_o & req_ready_i & sel_wr;
	assign s_rsp_o.ar_ready = req_valid_o & req_ready_i & ~sel_wr;

	always_ff @(posedge sys_clk or negedge ndmreset_n) begin
		if (!ndmreset_n) begin
			last_wr_q <= 1'b0;
			lock_q    <= 1'b0;
			lock_wr_q <= 1'b0;
		end else begin
			lock_q    <= req_valid_o & ~req_ready_i;
			lock_wr_q <= sel_wr;
			if (req_valid_o && req_ready_i) begin
				last_wr_q <= sel_wr;
			end
		end
	end

	// ----------------------------------------
	// response side
	// ----------------------------------------
	// the we bit picks B or R
	assign s_rsp_o.b_valid = rsp_valid_i & rsp_i.we;
	assign s_rsp_o.b_resp  = rsp_i.resp;
	assign s_rsp_o.r_valid = rsp_valid_i & ~rsp_i.we;
	assign s_rsp_o.r_data  = rsp_i.rdata;
	assign s_rsp_o.r_resp  = rsp_i.resp;
	assign rsp_ready_o     = rsp_i.we ? s_req_i.b_ready : s_req_i.r_ready;

	// a stalled request keeps its direction
	assert property (@(posedge sys_clk) disable iff (!ndmreset_n)
		req_valid_o && !req_ready_i |=> req_valid_o && req_o.we == $past(req_o.we));

endmodule

/* hw/pipe_slice.sv */
// two-entry register slice, full throughput, registered outputs
// in_ready_o depends on slice state only
module pipe_slice #(
	parameter type payload_t = soc_fabric_pkg::fab_req_t
) (
	input  logic     sys_clk,
	input  logic     ndmreset_n,
	input  logic     in_valid_i,
	output logic     in_ready_o,
	input  payload_t in_i,
	output logic     out_valid_o,
	input  logic     out_ready_i,
	output payload_t out_o
);
	logic     out_valid_q;
	logic     skid_valid_q;
	payload_t out_q;
	payload_t skid_q;
	logic     load_out;

	assign in_ready_o  = ~skid_valid_q;
	assign out_valid_o = out_valid_q;
	assign out_o       = out_q;

	// output register can take a new entry
	assign load_out = out_ready_i | ~out_valid_q;

	always_ff @(posedge sys_clk or negedge ndmreset_n) begin
		if (!ndmreset_n) begin
			out_valid_q  <= 1'b0;
			skid_valid_q <= 1'b0;
		end else if (load_out) begin
			out_valid_q  <= skid_valid_q | in_valid_i;
			skid_valid_q <= 1'b0;
		end else if (in_valid_i && !skid_valid_q) begin
			skid_valid_q <= 1'b1;
		end
	end

	// skid entry drains first, keeps order
	always_ff @(posedge sys_clk) begin
		if (load_out) begin
			out_q <= skid_valid_q ? skid_q : in_i;
		end else if (in_valid_i && !skid_valid_q) begin
			skid_q <= in_i;
		end
	end

	assert property (@(posedge sys_clk) disable iff (!ndmreset_n)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o));

endmodule

/* hw/addr_decoder.sv */
// one access at a time; address is rebased to the target window
// unmapped addresses answer DECERR without touching any target
module addr_decoder (
	input  logic                     sys_clk,
	input  logic                     ndmreset_n,
	input  logic                     req_valid_i,
	output logic                     req_ready_o,
	input  soc_fabric_pkg::fab_req_t req_i,
	output logic                     rsp_valid_o,
	input  logic                     rsp_ready_i,
	output soc_fabric_pkg::fab_rsp_t rsp_o,
	output logic                     mem_valid_o,
	input  logic                     mem_ready_i,
	input  logic                     mem_rsp_valid_i,
	input  soc_fabric_pkg::fab_rsp_t mem_rsp_i,
	output logic                     perip_valid_o,
	input  logic                     perip_ready_i,
	input  logic                     perip_rsp_valid_i,
	input  soc_fabric_pkg::fab_rsp_t perip_rsp_i,
	output logic                     clint_valid_o,
	input  logic                     clint_rsp_valid_i,
	input  soc_fabric_pkg::fab_rsp_t clint_rsp_i,
	output soc_fabric_pkg::fab_req_t tgt_req_o
);
	import soc_fabric_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_WAIT, ST_RESP} state_e;

	state_e            state_q;
	tgt_e              tgt_q;
	tgt_e              tgt_d;
	logic [ADDR_W-1:0] base_d;
	fab_req_t          req_q;
	fab_rsp_t          rsp_q;
	logic              issue_done;
	logic              tgt_rsp_valid;
	fab_rsp_t          tgt_rsp;

	// window lookup, unsigned offset against length
	always_comb begin
		tgt_d  = TGT_NONE;
		base_d = '0;
		if ((req_i.addr - DRAM_BASE) < DRAM_LEN) begin
			tgt_d  = TGT_DRAM;
			base_d = DRAM_BASE;
		end else if ((req_i.addr - PERIP_BASE) < PERIP_LEN) begin
			tgt_d  = TGT_PERIP;
			base_d = PERIP_BASE;
		end else if ((req_i.addr - CLINT_BASE) < CLINT_LEN) begin
			tgt_d  = TGT_CLINT;
			base_d = CLINT_BASE;
		end
	end

	// clint takes a request without a ready
	always_comb begin
		case (tgt_q)
			TGT_DRAM: begin
				issue_done    = mem_ready_i;
				tgt_rsp_valid = mem_rsp_valid_i;
				tgt_rsp       = mem_rsp_i;
			end
			TGT_PERIP: begin
				issue_done    = perip_ready_i;
				tgt_rsp_valid = perip_rsp_valid_i;
				tgt_rsp       = perip_rsp_i;
			end
			default: begin
				issue_done    = 1'b1;
				tgt_rsp_valid = clint_rsp_valid_i;
				tgt_rsp       = clint_rsp_i;
			end
		endcase
	end

	assign req_ready_o   = (state_q == ST_IDLE);
	assign tgt_req_o     = req_q;
	assign mem_valid_o   = (state_q == ST_ISSUE) && (tgt_q == TGT_DRAM);
	assign perip_valid_o = (state_q == ST_ISSUE) && (tgt_q == TGT_PERIP);
	assign clint_valid_o = (state_q == ST_ISSUE) && (tgt_q == TGT_CLINT);
	assign rsp_valid_o   = (state_q == ST_RESP);
	assign rsp_o         = rsp_q;

	always_ff @(posedge sys_clk or negedge ndmreset_n) begin
		if (!ndmreset_n) begin
			state_q <= ST_IDLE;
			tgt_q   <= TGT_NONE;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (req_valid_i) begin
						tgt_q   <= tgt_d;
						state_q <= (tgt_d == TGT_NONE) ? ST_RESP : ST_ISSUE;
					end
				end
				ST_ISSUE: begin
					if (issue_done) begin
						state_q <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (tgt_rsp_valid) begin
						state_q <= ST_RESP;
					end
				end
				default: begin
					if (rsp_ready_i) begin
						state_q <= ST_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state_q == ST_IDLE && req_valid_i) begin
			req_q.we    <= req_i.we;
			req_q.addr  <= req_i.addr - base_d;
			req_q.wdata <= req_i.wdata;
			req_q.wstrb <= req_i.wstrb;
			// preset for the unmapped case
			rsp_q <= '{we: req_i.we, rdata: '0, resp: RESP_DECERR};
		end else if (state_q == ST_WAIT && tgt_rsp_valid) begin
			rsp_q <= tgt_rsp;
		end
	end

	// at most one target answers in a cycle
	assert property (@(posedge sys_clk) disable iff (!ndmreset_n)
		$onehot0({mem_rsp_valid_i, perip_rsp_valid_i, clint_rsp_valid_i}));

endmodule

/* hw/clint_regs.sv */
// single-hart machine timer, mtime runs at half the clock rate
// accepts every request and answers the next cycle
module clint_regs (
	input  logic                     sys_clk,
	input  logic                     ndmreset_n,
	input  logic                     req_valid_i,
	input  soc_fabric_pkg::fab_req_t req_i,
	output logic                     rsp_valid_o,
	output soc_fabric_pkg::fab_rsp_t rsp_o,
	output logic                     timer_irq_o,
	output logic                     ipi_o
);
	import soc_fabric_pkg::*;

	logic              rtc_q;
	logic [DATA_W-1:0] mtime_q;
	logic [DATA_W-1:0] mtimecmp_q;
	logic              msip_q;
	logic              rsp_valid_q;
	fab_rsp_t          rsp_q;
	logic              wr_sel;
	logic [DATA_W-1:0] rdata;

	// byte-wise merge under wstrb
	function automatic logic [DATA_W-1:0] apply_strb(input logic [DATA_W-1:0] old_val,
			input logic [DATA_W-1:0] new_val, input logic [STRB_W-1:0] strb);
		logic [DATA_W-1:0] res;
		int                i;
		res = old_val;
		for (i = 0; i < STRB_W; i++) begin
			if (strb[i]) begin
				res[8*i +: 8] = new_val[8*i +: 8];
			end
		end
		return res;
	endfunction

	assign wr_sel = req_valid_i & req_i.we;

	// unknown offsets read as zero
	always_comb begin
		case (req_i.addr)
			MSIP_OFS:     rdata = {{(DATA_W-1){1'b0}}, msip_q};
			MTIMECMP_OFS: rdata = mtimecmp_q;
			MTIME_OFS:    rdata = mtime_q;
			default:      rdata = '0;
		endcase
	end

	always_ff @(posedge sys_clk or negedge ndmreset_n) begin
		if (!ndmreset_n) begin
			rtc_q       <= 1'b0;
			mtime_q     <= '0;
			mtimecmp_q  <= '1;
			msip_q      <= 1'b0;
			rsp_valid_q <= 1'b0;
		end else begin
			rtc_q       <= ~rtc_q;
			rsp_valid_q <= req_valid_i;
			// software write wins over the tick
			if (wr_sel && req_i.addr == MTIME_OFS) begin
				mtime_q <= apply_strb(mtime_q, req_i.wdata, req_i.wstrb);
			end else if (rtc_q) begin
				mtime_q <= mtime_q + 1'b1;
			end
			if (wr_sel && req_i.addr == MTIMECMP_OFS) begin
				mtimecmp_q <= apply_strb(mtimecmp_q, req_i.wdata, req_i.wstrb);
			end
			if (wr_sel && req_i.addr == MSIP_OFS && req_i.wstrb[0]) begin
				msip_q <= req_i.wdata[0];
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (req_valid_i) begin
			rsp_q <= '{we: req_i.we, rdata: rdata, resp: RESP_OKAY};
		end
	end

	assign rsp_valid_o = rsp_valid_q;
	assign rsp_o       = rsp_q;
	assign ipi_o       = msip_q;
	assign timer_irq_o = (mtime_q >= mtimecmp_q);

endmodule

/* hw/axil_master_port.sv */
// one outstanding access on an external AXI4-Lite master port
// the address arrives already rebased to the window
module axil_master_port (
	input  logic                      sys_clk,
	input  logic                      ndmreset_n,
	input  logic                      req_valid_i,
	output logic                      req_ready_o,
	input  soc_fabric_pkg::fab_req_t  req_i,
	output logic                      rsp_valid_o,
	input  soc_fabric_pkg::axil_rsp_t rsp_i,
	output soc_fabric_pkg::fab_rsp_t  rsp_o,
	output soc_fabric_pkg::axil_req_t axil_o
);
	import soc_fabric_pkg::*;

	typedef enum logic [1:0] {MP_IDLE, MP_WRITE, MP_READ} state_e;

	state_e   state_q;
	logic     aw_pend_q;
	logic     w_pend_q;
	logic     ar_pend_q;
	fab_req_t req_q;
	logic     b_done;
	logic     r_done;

	assign req_ready_o = (state_q == MP_IDLE);

	assign axil_o.aw_addr  = req_q.addr;
	assign axil_o.aw_valid = aw_pend_q;
	assign axil_o.w_data   = req_q.wdata;
	assign axil_o.w_strb   = req_q.wstrb;
	assign axil_o.w_valid  = w_pend_q;
	assign axil_o.b_ready  = (state_q == MP_WRITE);
	assign axil_o.ar_addr  = req_q.addr;
	assign axil_o.ar_valid = ar_pend_q;
	assign axil_o.r_ready  = (state_q == MP_READ);

	// the decoder always has room for the one response it waits on
	assign b_done      = axil_o.b_ready & rsp_i.b_valid;
	assign r_done      = axil_o.r_ready & rsp_i.r_valid;
	assign rsp_valid_o = b_done | r_done;
	assign rsp_o.we    = (state_q == MP_WRITE);
	assign rsp_o.rdata = (state_q == MP_WRITE) ? '0 : rsp_i.r_data;
	assign rsp_o.resp  = (state_q == MP_WRITE) ? rsp_i.b_resp : rsp_i.r_resp;

	always_ff @(posedge sys_clk or negedge ndmreset_n) begin
		if (!ndmreset_n) begin
			state_q   <= MP_IDLE;
			aw_pend_q <= 1'b0;
			w_pend_q  <= 1'b0;
			ar_pend_q <= 1'b0;
		end else begin
			case (state_q)
				MP_IDLE: begin
					if (req_valid_i) begin
						aw_pend_q <= req_i.we;
						w_pend_q  <= req_i.we;
						ar_pend_q <= ~req_i.we;
						state_q   <= req_i.we ? MP_WRITE : MP_READ;
					end
				end
				MP_WRITE: begin
					// AW and W complete independently
					if (rsp_i.aw_ready) begin
						aw_pend_q <= 1'b0;
					end
					if (rsp_i.w_ready) begin
						w_pend_q <= 1'b0;
					end
					if (b_done) begin
						state_q <= MP_IDLE;
					end
				end
				MP_READ: begin
					if (rsp_i.ar_ready) begin
						ar_pend_q <= 1'b0;
					end
					if (r_done) begin
						state_q <= MP_IDLE;
					end
				end
				default: state_q <= MP_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state_q == MP_IDLE && req_valid_i) begin
			req_q <= req_i;
		end
	end

	// the slave must not answer before both address and data went out
	assert property (@(posedge sys_clk) disable iff (!ndmreset_n)
		b_done |-> !aw_pend_q && !w_pend_q);

endmodule

/* hw/soc_fabric.sv */
// fabric top: front end, request slice, decoder, response slice
// DRAM and peripheral windows leave on AXI4-Lite, CLINT is local
module soc_fabric (
	input  logic                      sys_clk,
	input  logic                      ndmreset_n,
	input  soc_fabric_pkg::axil_req_t s_req_i,
	output soc_fabric_pkg::axil_rsp_t s_rsp_o,
	output soc_fabric_pkg::axil_req_t mem_req_o,
	input  soc_fabric_pkg::axil_rsp_t mem_rsp_i,
	output soc_fabric_pkg::axil_req_t perip_req_o,
	input  soc_fabric_pkg::axil_rsp_t perip_rsp_i,
	output logic                      timer_irq_o,
	output logic                      ipi_o
);
	import soc_fabric_pkg::*;

	logic     fe_req_valid;
	logic     fe_req_ready;
	fab_req_t fe_req;
	logic     dq_valid;
	logic     dq_ready;
	fab_req_t dq_req;
	logic     dr_valid;
	logic     dr_ready;
	fab_rsp_t dr_rsp;
	logic     fr_valid;
	logic     fr_ready;
	fab_rsp_t fr_rsp;

	// decoder to targets
	fab_req_t tgt_req;
	logic     mem_valid;
	logic     mem_ready;
	logic     mem_rsp_valid;
	fab_rsp_t mem_rsp;
	logic     perip_valid;
	logic     perip_ready;
	logic     perip_rsp_valid;
	fab_rsp_t perip_rsp;
	logic     clint_valid;
	logic     clint_rsp_valid;
	fab_rsp_t clint_rsp;

	axil_front u_front (
		.sys_clk     (sys_clk),
		.ndmreset_n  (ndmreset_n),
		.s_req_i     (s_req_i),
		.s_rsp_o     (s_rsp_o),
		.req_valid_o (fe_req_valid),
		.req_ready_i (fe_req_ready),
		.req_o       (fe_req),
		.rsp_valid_i (fr_valid),
		.rsp_ready_o (fr_ready),
		.rsp_i       (fr_rsp)
	);

	pipe_slice #(.payload_t(fab_req_t)) u_req_slice (
		.sys_clk     (sys_clk),
		.ndmreset_n  (ndmreset_n),
		.in_valid_i  (fe_req_valid),
		.in_ready_o  (fe_req_ready),
		.in_i        (fe_req),
		.out_valid_o (dq_valid),
		.out_ready_i (dq_ready),
		.out_o       (dq_req)
	);

	addr_decoder u_decoder (
		.sys_clk           (sys_clk),
		.ndmreset_n        (ndmreset_n),
		.req_valid_i       (dq_valid),
		.req_ready_o       (dq_ready),
		.req_i             (dq_req),
		.rsp_valid_o       (dr_valid),
		.rsp_ready_i       (dr_ready),
		.rsp_o             (dr_rsp),
		.mem_valid_o       (mem_valid),
		.mem_ready_i       (mem_ready),
		.mem_rsp_valid_i   (mem_rsp_valid),
		.mem_rsp_i         (mem_rsp),
		.perip_valid_o     (perip_valid),
		.perip_ready_i     (perip_ready),
		.perip_rsp_valid_i (perip_rsp_valid),
		.perip_rsp_i       (perip_rsp),
		.clint_valid_o     (clint_valid),
		.clint_rsp_valid_i (clint_rsp_valid),
		.clint_rsp_i       (clint_rsp),
		.tgt_req_o         (tgt_req)
	);

	pipe_slice #(.payload_t(fab_rsp_t)) u_rsp_slice (
		.sys_clk     (sys_clk),
		.ndmreset_n  (ndmreset_n),
		.in_valid_i  (dr_valid),
		.in_ready_o  (dr_ready),
		.in_i        (dr_rsp),
		.out_valid_o (fr_valid),
		.out_ready_i (fr_ready),
		.out_o       (fr_rsp)
	);

	clint_regs u_clint (
		.sys_clk     (sys_clk),
		.ndmreset_n  (ndmreset_n),
		.req_valid_i (clint_valid),
		.req_i       (tgt_req),
		.rsp_valid_o (clint_rsp_valid),
		.rsp_o       (clint_rsp),
		.timer_irq_o (timer_irq_o),
		.ipi_o       (ipi_o)
	);

	axil_master_port u_mem_port (
		.sys_clk     (sys_clk),
		.ndmreset_n  (ndmreset_n),
		.req_valid_i (mem_valid),
		.req_ready_o (mem_ready),
		.req_i       (tgt_req),
		.rsp_valid_o (mem_rsp_valid),
		.rsp_i       (mem_rsp_i),
		.rsp_o       (mem_rsp),
		.axil_o      (mem_req_o)
	);

	axil_master_port u_perip_port (
		.sys_clk     (sys_clk),
		.ndmreset_n  (ndmreset_n),
		.req_valid_i (perip_valid),
		.req_ready_o (perip_ready),
		.req_i       (tgt_req),
		.rsp_valid_o (perip_rsp_valid),
		.rsp_i       (perip_rsp_i),
		.rsp_o       (perip_rsp),
		.axil_o      (perip_req_o)
	);

endmodule

/* tests/tb_soc_fabric.sv */
// directed tests through the AXI4-Lite slave port of the fabric
// DRAM and peripheral windows are answered by two 64-word memory models
// inputs change 1 unit after the rising edge, outputs are sampled on the falling edge
module axil_mem_model #(
	parameter logic [31:0] SEED = 32'd96531
) (
	input  logic                      sys_clk,
	input  logic                      ndmreset_n,
	input  soc_fabric_pkg::axil_req_t req_i,
	output soc_fabric_pkg::axil_rsp_t rsp_o,
	output logic [31:0]               last_addr_o,
	output int                        access_cnt_o
);
	import soc_fabric_pkg::*;

	logic [DATA_W-1:0] mem [64];
	logic [31:0]       lcg_state;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// zero to three idle cycles before a ready
	task automatic ready_delay();
		int n;
		n = int'((lcg_next() >> 16) % 32'd4);
		repeat (n) begin
			@(posedge sys_clk);
			#1;
		end
	endtask

	initial begin
		int                i;
		logic [5:0]        idx;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] wstrb;
		rsp_o        = '0;
		last_addr_o  = '0;
		access_cnt_o = 0;
		lcg_state    = SEED;
		// fill depends on the full word index
		for (i = 0; i < 64; i++) begin
			mem[i] = {32'hC0DE_0000 | 32'(i), ~32'(i)};
		end
		forever begin
			@(posedge sys_clk);
			#1;
			if (!ndmreset_n) begin
				rsp_o = '0;
			end else if (req_i.aw_valid && req_i.w_valid) begin
				access_cnt_o++;
				last_addr_o = req_i.aw_addr;
				idx         = req_i.aw_addr[8:3];
				wdata       = req_i.w_data;
				wstrb       = req_i.w_strb;
				ready_delay();
				rsp_o.aw_ready = 1'b1;
				rsp_o.w_ready  = 1'b1;
				@(posedge sys_clk);
				#1;
				rsp_o.aw_ready = 1'b0;
				rsp_o.w_ready  = 1'b0;
				for (i = 0; i < STRB_W; i++) begin
					if (wstrb[i]) begin
						mem[idx][8*i +: 8] = wdata[8*i +: 8];
					end
				end
				rsp_o.b_resp  = RESP_OKAY;
				rsp_o.b_valid = 1'b1;
				@(negedge sys_clk);
				while (!req_i.b_ready) @(negedge sys_clk);
				@(posedge sys_clk);
				#1;
				rsp_o.b_valid = 1'b0;
			end else if (req_i.ar_valid) begin
				access_cnt_o++;
				last_addr_o = req_i.ar_addr;
				idx         = req_i.ar_addr[8:3];
				ready_delay();
				rsp_o.ar_ready = 1'b1;
				@(posedge sys_clk);
				#1;
				rsp_o.ar_ready = 1'b0;
				rsp_o.r_data   = mem[idx];
				rsp_o.r_resp   = RESP_OKAY;
				rsp_o.r_valid  = 1'b1;
				@(negedge sys_clk);
				while (!req_i.r_ready) @(negedge sys_clk);
				@(posedge sys_clk);
				#1;
				rsp_o.r_valid = 1'b0;
			end
		end
	end

endmodule

module tb_soc_fabric;
	import soc_fabric_pkg::*;

	// about 200 transactions of 50 cycles plus timer waits, doubled
	localparam int TIMEOUT = 20000;

	logic        sys_clk;
	logic        ndmreset_n;
	axil_req_t   s_req;
	axil_rsp_t   s_rsp;
	axil_req_t   mem_req;
	axil_rsp_t   mem_rsp;
	axil_req_t   perip_req;
	axil_rsp_t   perip_rsp;
	logic        timer_irq;
	logic        ipi;
	logic [31:0] mem_last_addr;
	int          mem_cnt;
	logic [31:0] perip_last_addr;
	int          perip_cnt;
	int          cycle_cnt = 0;
	int          errors = 0;
	int          tests_run = 0;
	logic [31:0] lcg_state = 32'd96531;

	soc_fabric u_soc_fabric (
		.sys_clk     (sys_clk),
		.ndmreset_n  (ndmreset_n),
		.s_req_i     (s_req),
		.s_rsp_o     (s_rsp),
		.mem_req_o   (mem_req),
		.mem_rsp_i   (mem_rsp),
		.perip_req_o (perip_req),
		.perip_rsp_i (perip_rsp),
		.timer_irq_o (timer_irq),
		.ipi_o       (ipi)
	);

	axil_mem_model u_mem_model (
		.sys_clk      (sys_clk),
		.ndmreset_n   (ndmreset_n),
		.req_i        (mem_req),
		.rsp_o        (mem_rsp),
		.last_addr_o  (mem_last_addr),
		.access_cnt_o (mem_cnt)
	);

	axil_mem_model u_perip_model (
		.sys_clk      (sys_clk),
		.ndmreset_n   (ndmreset_n),
		.req_i        (perip_req),
		.rsp_o        (perip_rsp),
		.last_addr_o  (perip_last_addr),
		.access_cnt_o (perip_cnt)
	);

	always #5 sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT) begin
			$display("Timeout after %0d cycles, the tests did not complete", cycle_cnt);
			$display("Verification failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		errors++;
		$display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	// ----------------------------------------
	// bus tasks, entered 1 unit after a rising edge
	// ----------------------------------------
	task automatic axil_write(input logic [31:0] addr, input logic [63:0] data,
			input logic [7:0] strb, output logic [1:0] resp);
		s_req.aw_addr  = addr;
		s_req.aw_valid = 1'b1;
		s_req.w_data   = data;
		s_req.w_strb   = strb;
		s_req.w_valid  = 1'b1;
		@(negedge sys_clk);
		while (!s_rsp.aw_ready) @(negedge sys_clk);
		// AW and W are accepted in the same cycle
		if (s_rsp.w_ready !== 1'b1) report_mismatch("w_ready", s_rsp.w_ready, 1);
		@(posedge sys_clk);
		#1;
		s_req.aw_valid = 1'b0;
		s_req.w_valid  = 1'b0;
		@(negedge sys_clk);
		while (!s_rsp.b_valid) @(negedge sys_clk);
		resp = s_rsp.b_resp;
		@(posedge sys_clk);
		#1;
	endtask

	task automatic issue_read(input logic [31:0] addr);
		s_req.ar_addr  = addr;
		s_req.ar_valid = 1'b1;
		@(negedge sys_clk);
		while (!s_rsp.ar_ready) @(negedge sys_clk);
		@(posedge sys_clk);
		#1;
		s_req.ar_valid = 1'b0;
	endtask

	task automatic axil_read(input logic [31:0] addr, output logic [63:0] data,
			output logic [1:0] resp);
		issue_read(addr);
		@(negedge sys_clk);
		while (!s_rsp.r_valid) @(negedge sys_clk);
		data = s_rsp.r_data;
		resp = s_rsp.r_resp;
		@(posedge sys_clk);
		#1;
	endtask

	// ----------------------------------------
	// tests
	// ----------------------------------------
	task automatic check_reset_state();
		tests_run++;
		if (s_rsp.b_valid !== 1'b0) report_mismatch("b_valid", s_rsp.b_valid, 0);
		if (s_rsp.r_valid !== 1'b0) report_mismatch("r_valid", s_rsp.r_valid, 0);
		if (timer_irq !== 1'b0) report_mismatch("timer_irq_o", timer_irq, 0);
		if (ipi !== 1'b0) report_mismatch("ipi_o", ipi, 0);
		if (mem_req.aw_valid !== 1'b0) report_mismatch("mem aw_valid", mem_req.aw_valid, 0);
		if (mem_req.w_valid !== 1'b0) report_mismatch("mem w_valid", mem_req.w_valid, 0);
		if (mem_req.ar_valid !== 1'b0) report_mismatch("mem ar_valid", mem_req.ar_valid, 0);
		if (perip_req.aw_valid !== 1'b0) report_mismatch("perip aw_valid", perip_req.aw_valid, 0);
		if (perip_req.w_valid !== 1'b0) report_mismatch("perip w_valid", perip_req.w_valid, 0);
		if (perip_req.ar_valid !== 1'b0) report_mismatch("perip ar_valid", perip_req.ar_valid, 0);
	endtask

	task automatic dram_write_read();
		logic [63:0] rdata;
		logic [1:0]  resp;
		int          perip_before;
		tests_run++;
		perip_before = perip_cnt;
		axil_write(DRAM_BASE + 32'h40, 64'h0123_4567_89AB_CDEF, 8'hFF, resp);
		if (resp !== RESP_OKAY) report_mismatch("b_resp", resp, RESP_OKAY);
		if (mem_last_addr !== 32'h40) report_mismatch("mem aw_addr", mem_last_addr, 32'h40);
		axil_read(DRAM_BASE + 32'h40, rdata, resp);
		if (resp !== RESP_OKAY) report_mismatch("r_resp", resp, RESP_OKAY);
		if (rdata !== 64'h0123_4567_89AB_CDEF) begin
			report_mismatch("r_data", rdata, 64'h0123_4567_89AB_CDEF);
		end
		if (mem_last_addr !== 32'h40) report_mismatch("mem ar_addr", mem_last_addr, 32'h40);
		if (perip_cnt != perip_before) report_failure("peripheral port was used by a DRAM access");
	endtask

	task automatic perip_random_access();
		logic [63:0] model [8];
		logic [5:0]  idx [8];
		logic [63:0] rdata;
		logic [63:0] patch;
		logic [1:0]  resp;
		int          mem_before;
		int          i;
		tests_run++;
		mem_before = mem_cnt;
		// one distinct word in each group of eight
		for (i = 0; i < 8; i++) begin
			idx[i]   = 6'(i * 8 + int'((lcg_next() >> 16) % 32'd8));
			model[i] = {lcg_next(), lcg_next()};
			axil_write(PERIP_BASE + {23'b0, idx[i], 3'b000}, model[i], 8'hFF, resp);
			if (resp !== RESP_OKAY) report_mismatch("b_resp", resp, RESP_OKAY);
			if (perip_last_addr !== {23'b0, idx[i], 3'b000}) begin
				report_mismatch("perip aw_addr", perip_last_addr, {23'b0, idx[i], 3'b000});
			end
		end
		// low half only
		patch = {lcg_next(), lcg_next()};
		axil_write(PERIP_BASE + {23'b0, idx[0], 3'b000}, patch, 8'h0F, resp);
		model[0] = {model[0][63:32], patch[31:0]};
		for (i = 0; i < 8; i++) begin
			axil_read(PERIP_BASE + {23'b0, idx[i], 3'b000}, rdata, resp);
			if (resp !== RESP_OKAY) report_mismatch("r_resp", resp, RESP_OKAY);
			if (rdata !== model[i]) report_mismatch("r_data", rdata, model[i]);
			if (perip_last_addr !== {23'b0, idx[i], 3'b000}) begin
				report_mismatch("perip ar_addr", perip_last_addr, {23'b0, idx[i], 3'b000});
			end
		end
		if (mem_cnt != mem_before) report_failure("DRAM port was used by a peripheral access");
	endtask

	task automatic unmapped_decerr();
		logic [63:0] rdata;
		logic [1:0]  resp;
		int          mem_before;
		int          perip_before;
		tests_run++;
		mem_before   = mem_cnt;
		perip_before = perip_cnt;
		axil_write(32'h1000_0000, 64'hFFFF_0000_FFFF_0000, 8'hFF, resp);
		if (resp !== RESP_DECERR) report_mismatch("b_resp", resp, RESP_DECERR);
		axil_read(32'h1000_0008, rdata, resp);
		if (resp !== RESP_DECERR) report_mismatch("r_resp", resp, RESP_DECERR);
		if (rdata !== 64'h0) report_mismatch("r_data", rdata, 0);
		if (mem_cnt != mem_before || perip_cnt != perip_before) begin
			report_failure("an unmapped address reached an external port");
		end
	endtask

	task automatic clint_timer_ipi();
		logic [63:0] t1;
		logic [63:0] t2;
		logic [1:0]  resp;
		int          c1;
		int          c2;
		longint      limit;
		int          waited;
		tests_run++;
		axil_write(CLINT_BASE + MSIP_OFS, 64'h1, 8'hFF, resp);
		if (resp !== RESP_OKAY) report_mismatch("b_resp", resp, RESP_OKAY);
		if (ipi !== 1'b1) report_mismatch("ipi_o", ipi, 1);
		axil_write(CLINT_BASE + MSIP_OFS, 64'h0, 8'hFF, resp);
		if (ipi !== 1'b0) report_mismatch("ipi_o", ipi, 0);

		// mtime ticks once every second cycle
		axil_read(CLINT_BASE + MTIME_OFS, t1, resp);
		c1 = cycle_cnt;
		repeat (25) @(posedge sys_clk);
		#1;
		axil_read(CLINT_BASE + MTIME_OFS, t2, resp);
		c2 = cycle_cnt;
		limit = longint'((c2 - c1) / 2 + 1);
		if (t2 <= t1) report_failure("mtime did not increase between two reads");
		if (t2 - t1 > 64'(limit)) report_failure("mtime advanced faster than half the clock rate");

		axil_read(CLINT_BASE + MTIME_OFS, t1, resp);
		axil_write(CLINT_BASE + MTIMECMP_OFS, t1 + 64'd20, 8'hFF, resp);
		if (timer_irq !== 1'b0) report_failure("timer_irq_o was high before mtime reached mtimecmp");
		waited = 0;
		while (timer_irq !== 1'b1 && waited < 60) begin
			@(posedge sys_clk);
			#1;
			waited++;
		end
		if (timer_irq !== 1'b1) report_failure("timer_irq_o did not rise within 60 cycles");
		axil_write(CLINT_BASE + MTIMECMP_OFS, '1, 8'hFF, resp);
		if (timer_irq !== 1'b0) report_mismatch("timer_irq_o", timer_irq, 0);
	endtask

	task automatic read_backpressure();
		logic [63:0] exp [4];
		logic [31:0] base;
		logic [1:0]  resp;
		int          i;
		tests_run++;
		base = DRAM_BASE + 32'h100;
		for (i = 0; i < 4; i++) begin
			exp[i] = {lcg_next(), lcg_next()};
			axil_write(base + 32'(i * 8), exp[i], 8'hFF, resp);
		end
		// stall the R channel so the slices fill
		s_req.r_ready = 1'b0;
		for (i = 0; i < 4; i++) begin
			issue_read(base + 32'(i * 8));
		end
		repeat (30) @(posedge sys_clk);
		#1;
		if (s_rsp.r_valid !== 1'b1) begin
			report_failure("no read response waiting while r_ready was low");
		end
		s_req.r_ready = 1'b1;
		for (i = 0; i < 4; i++) begin
			@(negedge sys_clk);
			while (!s_rsp.r_valid) @(negedge sys_clk);
			if (s_rsp.r_resp !== RESP_OKAY) report_mismatch("r_resp", s_rsp.r_resp, RESP_OKAY);
			if (s_rsp.r_data !== exp[i]) report_mismatch("r_data", s_rsp.r_data, exp[i]);
			@(posedge sys_clk);
			#1;
		end
	endtask

	initial begin
		sys_clk       = 1'b0;
		ndmreset_n    = 1'b0;
		s_req         = '0;
		s_req.b_ready = 1'b1;
		s_req.r_ready = 1'b1;
		repeat (5) @(posedge sys_clk);
		#1;
		ndmreset_n = 1'b1;

		check_reset_state();
		dram_write_read();
		perip_random_access();
		unmapped_decerr();
		clint_timer_ipi();
		read_backpressure();

		$display("tests run: %0d, errors: %0d", tests_run, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* soc_fabric.f */
hw/soc_fabric_pkg.sv
hw/axil_front.sv
hw/pipe_slice.sv
hw/addr_decoder.sv
hw/clint_regs.sv
hw/axil_master_port.sv
hw/soc_fabric.sv
tests/tb_soc_fabric.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_fabric \
		-f soc_fabric.f -Mdir obj_dir -o tb_soc_fabric

run: compile
	./obj_dir/tb_soc_fabric | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
